// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := frontend_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: sim clean

# a crashed or stopped run also counts as a failure
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "=== FAIL ===" >> $(LOG)
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
logic/fetch_pkg.sv
logic/gselect_predictor.sv
logic/next_pc_select.sv
logic/fetch_unit.sv
logic/inst_queue.sv
logic/frontend_top.sv
verification/line_memory_model.sv
verification/frontend_tb.sv

// File: logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // datapath and line geometry
    localparam int XLEN           = 32;
    localparam int LINE_BITS      = 256;
    localparam int WORDS_PER_LINE = LINE_BITS / XLEN;
    localparam int OFFSET_BITS    = $clog2(LINE_BITS / 8);

    typedef logic [LINE_BITS-1:0] line_t;

    localparam logic [XLEN-1:0] RESET_PC = 32'haaaaa000;

    // opcodes seen by predecode
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // gselect sizing, index is {pc bits, history}
    localparam int         PC_INDEX_BITS = 4;
    localparam int         GHR_BITS      = 4;
    localparam int         PRED_ENTRIES  = 1 << (PC_INDEX_BITS + GHR_BITS);
    localparam logic [1:0] COUNTER_INIT  = 2'b01;

    localparam int IQ_DEPTH = 16;

    // one instruction word, viewed as B-type or J-type
    typedef union packed {
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_form;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_form;
    } inst_u;

endpackage : fetch_pkg

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                       clk,
    input  logic                       rst,

    // line port
    input  fetch_pkg::line_t           line_data_i,
    input  logic                       line_valid_i,
    output logic                       line_req_o,
    output logic [fetch_pkg::XLEN-1:0] line_addr_o,

    // redirect from the back end
    input  logic                       redirect_i,
    input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,

    // queue side
    input  logic                       iq_full_i,
    output logic                       push_o,
    output logic [fetch_pkg::XLEN-1:0] push_inst_o,
    output logic [fetch_pkg::XLEN-1:0] push_pc_o,
    output logic                       push_pred_o,

    // predecode loop
    input  logic [fetch_pkg::XLEN-1:0] next_pc_i,
    input  logic                       pred_i,
    output logic [fetch_pkg::XLEN-1:0] fetch_pc_o,
    output logic [fetch_pkg::XLEN-1:0] fetch_inst_o
);
    import fetch_pkg::*;

    logic [XLEN-1:0]                     pc_q;
    line_t                               line_q;
    logic [XLEN-1:OFFSET_BITS]           line_tag_q;
    logic                                line_valid_q;
    logic                                line_req_q;
    logic [XLEN-1:0]                     line_addr_q;
    logic                                outstanding_q;
    logic                                stale_q;
    logic                                hit;
    logic                                need_line;
    logic [$clog2(WORDS_PER_LINE)-1:0]   word_sel;

    assign hit = line_valid_q && (line_tag_q == pc_q[XLEN-1:OFFSET_BITS]);

    // no new request on a redirect edge, the pc is about to move
    assign need_line = !hit && !outstanding_q && !redirect_i;

    assign word_sel     = pc_q[OFFSET_BITS-1:2];
    assign fetch_pc_o   = pc_q;
    assign fetch_inst_o = line_q[word_sel*XLEN +: XLEN];

    // one word per cycle while the pc stays in the buffered line
    assign push_o      = hit && !iq_full_i;
    assign push_inst_o = fetch_inst_o;
    assign push_pc_o   = pc_q;
    assign push_pred_o = pred_i;

    assign line_req_o  = line_req_q;
    assign line_addr_o = line_addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q          <= RESET_PC;
            line_valid_q  <= 1'b0;
            line_req_q    <= 1'b0;
            outstanding_q <= 1'b0;
            stale_q       <= 1'b0;
        end else begin
            line_req_q <= 1'b0;

            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (push_o) begin
                pc_q <= next_pc_i;
            end

            if (line_valid_i) begin
                // a stale answer only frees the port
                outstanding_q <= 1'b0;
                stale_q       <= 1'b0;
                if (!stale_q) begin
                    line_valid_q <= 1'b1;
                end
            end else if (redirect_i && outstanding_q) begin
                stale_q <= 1'b1;
            end else if (need_line) begin
                line_req_q    <= 1'b1;
                outstanding_q <= 1'b1;
            end
        end
    end

    // line data, tag and request address
    always_ff @(posedge clk) begin
        if (need_line) begin
            line_addr_q <= {pc_q[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        end
        if (line_valid_i && !stale_q) begin
            line_q     <= line_data_i;
            line_tag_q <= line_addr_q[XLEN-1:OFFSET_BITS];
        end
    end

    // no new request while a dropped answer is still due
    one_outstanding: assert property (
        @(posedge clk) disable iff (rst)
        stale_q |-> !line_req_o
    );

endmodule : fetch_unit

`default_nettype wire

// File: logic/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
    input  logic                       clk,
    input  logic                       rst,

    // line port
    output logic                       line_req_o,
    output logic [fetch_pkg::XLEN-1:0] line_addr_o,
    input  fetch_pkg::line_t           line_data_i,
    input  logic                       line_valid_i,

    // queue head
    output logic                       iq_empty_o,
    output logic [fetch_pkg::XLEN-1:0] iq_inst_o,
    output logic [fetch_pkg::XLEN-1:0] iq_pc_o,
    output logic                       iq_pred_o,
    input  logic                       pop_i,

    // redirect and training
    input  logic                       redirect_i,
    input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
    input  logic                       update_i,
    input  logic [fetch_pkg::XLEN-1:0] update_pc_i,
    input  logic                       update_taken_i
);
    import fetch_pkg::*;

    logic [XLEN-1:0] fetch_pc;
    logic [XLEN-1:0] fetch_inst;
    logic            predict_taken;
    logic [XLEN-1:0] next_pc;
    logic            pred;
    logic            push;
    logic [XLEN-1:0] push_inst;
    logic [XLEN-1:0] push_pc;
    logic            push_pred;
    logic            iq_full;

    fetch_unit i_fetch_unit (
        .clk           (clk),
        .rst           (rst),
        .line_data_i   (line_data_i),
        .line_valid_i  (line_valid_i),
        .line_req_o    (line_req_o),
        .line_addr_o   (line_addr_o),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .iq_full_i     (iq_full),
        .push_o        (push),
        .push_inst_o   (push_inst),
        .push_pc_o     (push_pc),
        .push_pred_o   (push_pred),
        .next_pc_i     (next_pc),
        .pred_i        (pred),
        .fetch_pc_o    (fetch_pc),
        .fetch_inst_o  (fetch_inst)
    );

    gselect_predictor i_gselect_predictor (
        .clk             (clk),
        .rst             (rst),
        .predict_pc_i    (fetch_pc),
        .update_i        (update_i),
        .update_pc_i     (update_pc_i),
        .update_taken_i  (update_taken_i),
        .predict_taken_o (predict_taken)
    );

    next_pc_select i_next_pc_select (
        .pc_i            (fetch_pc),
        .inst_i          (fetch_inst),
        .predict_taken_i (predict_taken),
        .next_pc_o       (next_pc),
        .pred_o          (pred)
    );

    // redirect also empties the queue
    inst_queue #(
        .DEPTH (IQ_DEPTH)
    ) i_inst_queue (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (redirect_i),
        .push_i      (push),
        .push_inst_i (push_inst),
        .push_pc_i   (push_pc),
        .push_pred_i (push_pred),
        .pop_i       (pop_i),
        .full_o      (iq_full),
        .empty_o     (iq_empty_o),
        .head_inst_o (iq_inst_o),
        .head_pc_o   (iq_pc_o),
        .head_pred_o (iq_pred_o)
    );

endmodule : frontend_top

`default_nettype wire

// File: logic/gselect_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module gselect_predictor (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [fetch_pkg::XLEN-1:0] predict_pc_i,
    input  logic                       update_i,
    input  logic [fetch_pkg::XLEN-1:0] update_pc_i,
    input  logic                       update_taken_i,
    output logic                       predict_taken_o
);
    import fetch_pkg::*;

    logic [1:0]                          counters [PRED_ENTRIES];
    logic [GHR_BITS-1:0]                 ghr_q;
    logic [PC_INDEX_BITS+GHR_BITS-1:0]   predict_idx;
    logic [PC_INDEX_BITS+GHR_BITS-1:0]   update_idx;
    logic [1:0]                          update_ctr;

    // word-address bits above the byte offset, then history
    assign predict_idx = {predict_pc_i[PC_INDEX_BITS+1:2], ghr_q};
    assign update_idx  = {update_pc_i[PC_INDEX_BITS+1:2], ghr_q};

    // msb of the counter is the taken guess
    assign predict_taken_o = counters[predict_idx][1];
    assign update_ctr      = counters[update_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PRED_ENTRIES; i++) begin
                counters[i] <= COUNTER_INIT;
            end
            ghr_q <= '0;
        end else if (update_i) begin
            // saturate toward the resolved direction
            if (update_taken_i) begin
                if (update_ctr != 2'b11) begin
                    counters[update_idx] <= update_ctr + 2'd1;
                end
            end else begin
                if (update_ctr != 2'b00) begin
                    counters[update_idx] <= update_ctr - 2'd1;
                end
            end
            // newest outcome enters at bit 0
            ghr_q <= {ghr_q[GHR_BITS-2:0], update_taken_i};
        end
    end

    // training only ever comes from real instruction addresses
    update_pc_aligned: assert property (
        @(posedge clk) disable iff (rst)
        update_i |-> (update_pc_i[1:0] == 2'b00)
    );

endmodule : gselect_predictor

`default_nettype wire

// File: logic/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
    parameter int DEPTH = fetch_pkg::IQ_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush_i,
    input  logic                       push_i,
    input  logic [fetch_pkg::XLEN-1:0] push_inst_i,
    input  logic [fetch_pkg::XLEN-1:0] push_pc_i,
    input  logic                       push_pred_i,
    input  logic                       pop_i,
    output logic                       full_o,
    output logic                       empty_o,
    output logic [fetch_pkg::XLEN-1:0] head_inst_o,
    output logic [fetch_pkg::XLEN-1:0] head_pc_o,
    output logic                       head_pred_o
);
    import fetch_pkg::*;

    logic [XLEN-1:0]          inst_mem [DEPTH];
    logic [XLEN-1:0]          pc_mem   [DEPTH];
    logic                     pred_mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(DEPTH):0]   count_q;
    logic                     do_push;
    logic                     do_pop;

    assign full_o  = (count_q == ($clog2(DEPTH)+1)'(DEPTH));
    assign empty_o = (count_q == '0);

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign head_inst_o = inst_mem[rd_ptr_q];
    assign head_pc_o   = pc_mem[rd_ptr_q];
    assign head_pred_o = pred_mem[rd_ptr_q];

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            inst_mem[wr_ptr_q] <= push_inst_i;
            pc_mem[wr_ptr_q]   <= push_pc_i;
            pred_mem[wr_ptr_q] <= push_pred_i;
        end
    end

    // fetch must stall on full
    no_push_when_full: assert property (
        @(posedge clk) disable iff (rst)
        push_i |-> !full_o
    );

endmodule : inst_queue

`default_nettype wire

// File: logic/next_pc_select.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc_select (
    input  logic [fetch_pkg::XLEN-1:0] pc_i,
    input  fetch_pkg::inst_u           inst_i,
    input  logic                       predict_taken_i,
    output logic [fetch_pkg::XLEN-1:0] next_pc_o,
    output logic                       pred_o
);
    import fetch_pkg::*;

    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] j_imm;
    logic            is_branch;
    logic            is_jal;

    // B-type immediate, bit 0 always zero
    assign b_imm = {{(XLEN-13){inst_i.b_form.imm_12}},
                    inst_i.b_form.imm_12,
                    inst_i.b_form.imm_11,
                    inst_i.b_form.imm_10_5,
                    inst_i.b_form.imm_4_1,
                    1'b0};

    // J-type immediate
    assign j_imm = {{(XLEN-21){inst_i.j_form.imm_20}},
                    inst_i.j_form.imm_20,
                    inst_i.j_form.imm_19_12,
                    inst_i.j_form.imm_11,
                    inst_i.j_form.imm_10_1,
                    1'b0};

    assign is_branch = (inst_i.b_form.opcode == OP_BRANCH);
    assign is_jal    = (inst_i.j_form.opcode == OP_JAL);

    always_comb begin
        next_pc_o = pc_i + 32'd4;
        pred_o    = 1'b0;
        if (is_jal) begin
            // unconditional, no need to ask the table
            next_pc_o = pc_i + j_imm;
            pred_o    = 1'b1;
        end else if (is_branch && predict_taken_i) begin
            next_pc_o = pc_i + b_imm;
            pred_o    = 1'b1;
        end
    end

endmodule : next_pc_select

`default_nettype wire

// File: verification/frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;
    import fetch_pkg::*;

    // branch table
    localparam logic [XLEN-1:0] JAL_FWD_PC  = 32'h0000_4010;
    localparam logic [XLEN-1:0] BRANCH_PC   = 32'h0000_4080;
    localparam logic [XLEN-1:0] JAL_BACK_PC = 32'h0000_4200;
    localparam logic [XLEN-1:0] LOOP_PC     = 32'h0000_4000;
    localparam int              WAIT_LIMIT  = 2000;

    logic            clk = 1'b0;
    logic            rst;
    logic            line_req;
    logic [XLEN-1:0] line_addr;
    line_t           line_data;
    logic            line_valid;
    logic            iq_empty;
    logic [XLEN-1:0] iq_inst;
    logic [XLEN-1:0] iq_pc;
    logic            iq_pred;
    logic            pop;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    logic            update;
    logic [XLEN-1:0] update_pc;
    logic            update_taken;
    logic [XLEN-1:0] rule_addr;
    line_t           rule_line;

    // mirror of the predictor
    logic [1:0]          ref_ctr [PRED_ENTRIES];
    logic [GHR_BITS-1:0] ref_ghr;

    string           test_name;
    logic            pop_enable;
    logic            timed_out;
    logic [XLEN-1:0] expected_pc;
    int              pop_count;
    int              word_errors;
    int              bit_errors;
    int              other_errors;
    int              taken_branches;
    int              fallthrough_branches;
    int              jals_seen;

    always #4 clk = ~clk;

    frontend_top i_frontend_top (
        .clk            (clk),
        .rst            (rst),
        .line_req_o     (line_req),
        .line_addr_o    (line_addr),
        .line_data_i    (line_data),
        .line_valid_i   (line_valid),
        .iq_empty_o     (iq_empty),
        .iq_inst_o      (iq_inst),
        .iq_pc_o        (iq_pc),
        .iq_pred_o      (iq_pred),
        .pop_i          (pop),
        .redirect_i     (redirect),
        .redirect_pc_i  (redirect_pc),
        .update_i       (update),
        .update_pc_i    (update_pc),
        .update_taken_i (update_taken)
    );

    line_memory_model i_line_memory_model (
        .clk          (clk),
        .line_req_i   (line_req),
        .line_addr_i  (line_addr),
        .rule_line_i  (rule_line),
        .rule_addr_o  (rule_addr),
        .line_data_o  (line_data),
        .line_valid_o (line_valid)
    );

    function automatic logic [XLEN-1:0] encode_branch(input logic [12:0] offset);
        inst_u word;
        word.b_form.imm_12   = offset[12];
        word.b_form.imm_10_5 = offset[10:5];
        word.b_form.rs2      = 5'd2;
        word.b_form.rs1      = 5'd1;
        word.b_form.funct3   = 3'b000;
        word.b_form.imm_4_1  = offset[4:1];
        word.b_form.imm_11   = offset[11];
        word.b_form.opcode   = OP_BRANCH;
        return word;
    endfunction

    function automatic logic [XLEN-1:0] encode_jal(input logic [20:0] offset);
        inst_u word;
        word.j_form.imm_20    = offset[20];
        word.j_form.imm_10_1  = offset[10:1];
        word.j_form.imm_11    = offset[11];
        word.j_form.imm_19_12 = offset[19:12];
        word.j_form.rd        = 5'd1;
        word.j_form.opcode    = OP_JAL;
        return word;
    endfunction

    function automatic logic [XLEN-1:0] program_word(input logic [XLEN-1:0] addr);
        case (addr)
            JAL_FWD_PC:  return encode_jal(21'h00040);
            BRANCH_PC:   return encode_branch(13'h0100);
            // back by 0x1f0, lands on JAL_FWD_PC
            JAL_BACK_PC: return encode_jal(21'h1ffe10);
            // addi x1, x0, low address bits
            default:     return {addr[11:0], 5'd0, 3'b000, 5'd1, 7'b0010011};
        endcase
    endfunction

    function automatic line_t build_line(input logic [XLEN-1:0] base);
        line_t line;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            line[i*XLEN +: XLEN] = program_word(base + 32'(4 * i));
        end
        return line;
    endfunction

    always_comb rule_line = build_line(rule_addr);

    // {prediction bit, next pc}, decoded straight from the raw bits
    function automatic logic [XLEN:0] expected_next(input logic [XLEN-1:0] pc);
        logic [XLEN-1:0] w;
        logic [XLEN-1:0] b_off;
        logic [XLEN-1:0] j_off;
        logic [7:0]      idx;
        w     = program_word(pc);
        b_off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        j_off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        idx   = {pc[5:2], ref_ghr};
        if (w[6:0] == 7'b1101111) begin
            return {1'b1, pc + j_off};
        end
        if (w[6:0] == 7'b1100011 && ref_ctr[idx][1]) begin
            return {1'b1, pc + b_off};
        end
        return {1'b0, pc + 32'd4};
    endfunction

    task automatic check_word(input string what, input logic [XLEN-1:0] expected,
                              input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("** Error [%s] %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            word_errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error [%s] %s: expected %b, actual %b",
                     test_name, what, expected, actual);
            bit_errors++;
        end
    endtask

    task automatic require(input logic cond, input string what);
        if (!cond) begin
            $display("[%s] %s", test_name, what);
            other_errors++;
        end
    endtask

    // head is stable one ns after the edge, pop takes it at the next edge
    always begin : pop_and_compare
        logic [XLEN:0] nxt;
        @(posedge clk);
        #1;
        if (pop_enable && !iq_empty) begin
            nxt = expected_next(expected_pc);
            check_word("popped pc", expected_pc, iq_pc);
            check_word("popped instruction", program_word(expected_pc), iq_inst);
            check_bit("prediction bit", nxt[XLEN], iq_pred);
            // direction as the front end reported it
            if (expected_pc == BRANCH_PC) begin
                if (iq_pred) begin
                    taken_branches++;
                end else begin
                    fallthrough_branches++;
                end
            end
            if ((expected_pc == JAL_FWD_PC || expected_pc == JAL_BACK_PC) && iq_pred) begin
                jals_seen++;
            end
            expected_pc = nxt[XLEN-1:0];
            pop_count++;
            pop = 1'b1;
        end else begin
            pop = 1'b0;
        end
    end

    task automatic wait_pops(input int n);
        int target;
        int cycles;
        target = pop_count + n;
        cycles = 0;
        while (!timed_out && pop_count < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("[%s] timeout, %0d entries never came out of the queue",
                         test_name, target - pop_count);
                other_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic pause_pops();
        @(negedge clk);
        pop_enable = 1'b0;
    endtask

    task automatic resume_pops(input logic [XLEN-1:0] pc);
        @(negedge clk);
        expected_pc = pc;
        pop_enable  = 1'b1;
    endtask

    task automatic redirect_to(input logic [XLEN-1:0] pc);
        @(posedge clk);
        #1;
        redirect    = 1'b1;
        redirect_pc = pc;
        @(posedge clk);
        #1;
        redirect = 1'b0;
    endtask

    task automatic train(input logic [XLEN-1:0] pc, input logic taken);
        logic [7:0] idx;
        @(posedge clk);
        #1;
        update       = 1'b1;
        update_pc    = pc;
        update_taken = taken;
        idx = {pc[5:2], ref_ghr};
        if (taken && ref_ctr[idx] != 2'b11) begin
            ref_ctr[idx] = ref_ctr[idx] + 2'd1;
        end else if (!taken && ref_ctr[idx] != 2'b00) begin
            ref_ctr[idx] = ref_ctr[idx] - 2'd1;
        end
        ref_ghr = {ref_ghr[GHR_BITS-2:0], taken};
        @(posedge clk);
        #1;
        update = 1'b0;
    endtask

    // the first 64 words span exactly 8 lines
    task automatic audit_line_requests();
        logic [XLEN-1:0] addr;
        int              in_window;
        in_window = 0;
        for (int i = 0; i < i_line_memory_model.req_count && i < 128; i++) begin
            addr = i_line_memory_model.req_log[i];
            require(addr[OFFSET_BITS-1:0] == '0, "line request address not line-aligned");
            if (addr >= RESET_PC && addr < RESET_PC + 32'd256) begin
                in_window++;
                for (int j = 0; j < i; j++) begin
                    require(i_line_memory_model.req_log[j] != addr,
                            "same line requested twice");
                end
            end
        end
        check_word("line requests", 32'd8, 32'(in_window));
    endtask

    initial begin
        rst          = 1'b1;
        pop          = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = '0;
        update       = 1'b0;
        update_pc    = '0;
        update_taken = 1'b0;
        pop_enable   = 1'b0;
        timed_out    = 1'b0;
        expected_pc  = RESET_PC;
        pop_count    = 0;
        word_errors  = 0;
        bit_errors   = 0;
        other_errors = 0;
        test_name    = "reset";
        for (int i = 0; i < PRED_ENTRIES; i++) begin
            ref_ctr[i] = COUNTER_INIT;
        end
        ref_ghr = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_bit("queue empty", 1'b1, iq_empty);
        check_bit("line request", 1'b0, line_req);

        test_name = "sequential";
        resume_pops(RESET_PC);
        wait_pops(64);
        audit_line_requests();

        // queue fills and fetch stalls
        test_name = "back-pressure";
        pause_pops();
        repeat (100) @(negedge clk);
        resume_pops(expected_pc);
        wait_pops(40);

        // second redirect lands while the first line is still outstanding
        test_name = "redirect";
        pause_pops();
        redirect_to(32'h0000_2004);
        redirect_to(32'h0000_3008);
        resume_pops(32'h0000_3008);
        wait_pops(20);

        test_name = "untrained";
        pause_pops();
        redirect_to(LOOP_PC);
        taken_branches       = 0;
        fallthrough_branches = 0;
        jals_seen            = 0;
        resume_pops(LOOP_PC);
        wait_pops(150);
        require(fallthrough_branches > 0, "untrained branch was never fetched");
        require(taken_branches == 0, "untrained branch was predicted taken");
        require(jals_seen > 0, "no JAL was popped as taken");

        test_name = "trained";
        pause_pops();
        repeat (6) train(BRANCH_PC, 1'b1);
        redirect_to(LOOP_PC);
        taken_branches = 0;
        resume_pops(LOOP_PC);
        wait_pops(150);
        require(taken_branches > 0, "trained branch was never predicted taken");

        pause_pops();
        $display("errors: %0d word, %0d bit, %0d other", word_errors, bit_errors, other_errors);
        if (word_errors + bit_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : frontend_tb

`default_nettype wire

// File: verification/line_memory_model.sv
`timescale 1ns/1ps
`default_nettype none

module line_memory_model (
    input  logic                       clk,
    input  logic                       line_req_i,
    input  logic [fetch_pkg::XLEN-1:0] line_addr_i,
    input  fetch_pkg::line_t           rule_line_i,
    output logic [fetch_pkg::XLEN-1:0] rule_addr_o,
    output fetch_pkg::line_t           line_data_o,
    output logic                       line_valid_o
);
    import fetch_pkg::*;

    localparam int LOG_SIZE = 128;

    int              seed;
    int              req_count;
    logic [XLEN-1:0] req_log [LOG_SIZE];

    initial begin : responder
        int delay;
        seed         = 28836;
        req_count    = 0;
        rule_addr_o  = '0;
        line_data_o  = '0;
        line_valid_o = 1'b0;
        forever begin
            // request pulse is sampled mid-cycle
            @(negedge clk);
            if (line_req_i) begin
                if (req_count < LOG_SIZE) begin
                    req_log[req_count] = line_addr_i;
                end
                req_count++;
                // tb turns this address into line words
                rule_addr_o = line_addr_i;
                delay = 2 + int'($unsigned($random(seed)) % 6);
                repeat (delay) @(posedge clk);
                #1;
                line_data_o  = rule_line_i;
                line_valid_o = 1'b1;
                @(posedge clk);
                #1;
                line_valid_o = 1'b0;
            end
        end
    end

endmodule : line_memory_model

`default_nettype wire
